//--- source/cpuPkg.sv
package cpuPkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC  = '0;
    // ADDI x0, x0, 0 is the canonical NOP.
    localparam logic [31:0]     NOP_INSTR = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_LINK
    } resultSrc_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MW
    } fwdSel_t;

    typedef struct packed {
        logic       regWrite;
        resultSrc_t resultSrc;
        logic       memWrite;
        logic       branch;
        logic       jump;
        logic       jalr;
        aluOp_t     aluOp;
        logic       aluSrc;
    } ctrl_t;

    localparam ctrl_t CTRL_BUBBLE = '0;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       extImm;
    } idEx_t;

    typedef struct packed {
        logic                  regWrite;
        resultSrc_t            resultSrc;
        logic                  memWrite;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       writeData;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rd;
    } exMw_t;

endpackage

//--- source/decodeExecuteReg.sv
`timescale 1ns/1ns

module decodeExecuteReg import cpuPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  flushE,
    input  idEx_t idExD,
    output idEx_t idExE
);

    idEx_t idExNext;

    // Only the control word needs clearing to make a bubble.
    always_comb begin
        idExNext = idExD;
        if (flushE) begin
            idExNext.ctrl = CTRL_BUBBLE;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idExE <= '0;
        end else begin
            idExE <= idExNext;
        end
    end

endmodule

//--- source/decodeUnit.sv
`timescale 1ns/1ns

module decodeUnit import cpuPkg::*; (
    input  logic [31:0]           instrD,
    input  logic [XLEN-1:0]       pcD,
    output idEx_t                 decoded,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2
);

    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immJ;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;

    assign opcode = opcode_t'(instrD[6:0]);
    assign funct3 = instrD[14:12];
    assign funct7 = instrD[31:25];
    assign rs1    = instrD[19:15];
    assign rs2    = instrD[24:20];

    assign immI = {{20{instrD[31]}}, instrD[31:20]};
    assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
    assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21], 1'b0};

    // Anything outside the supported subset falls through as a bubble.
    always_comb begin
        ctrl = CTRL_BUBBLE;
        imm  = immI;
        case (opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  ctrl.aluOp = ALU_SLT;
                    3'b100:  ctrl.aluOp = ALU_XOR;
                    3'b110:  ctrl.aluOp = ALU_OR;
                    3'b111:  ctrl.aluOp = ALU_AND;
                    default: ctrl = CTRL_BUBBLE;
                endcase
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl = CTRL_BUBBLE;
                end
            end
            OP_IMM: begin
                ctrl.regWrite = (funct3 == 3'b000);
                ctrl.aluSrc   = 1'b1;
            end
            LOAD: begin
                ctrl.regWrite  = (funct3 == 3'b010);
                ctrl.resultSrc = (funct3 == 3'b010) ? RES_MEM : RES_ALU;
                ctrl.aluSrc    = 1'b1;
            end
            STORE: begin
                ctrl.memWrite = (funct3 == 3'b010);
                ctrl.aluSrc   = 1'b1;
                imm           = immS;
            end
            BRANCH: begin
                ctrl.branch = (funct3 == 3'b000);
                imm         = immB;
            end
            JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = RES_LINK;
                ctrl.jump      = 1'b1;
                imm            = immJ;
            end
            JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSrc = RES_LINK;
                    ctrl.jump      = 1'b1;
                    ctrl.jalr      = 1'b1;
                end
            end
            default: ctrl = CTRL_BUBBLE;
        endcase
    end

    // Register data is merged in by the top level.
    assign decoded = '{ctrl: ctrl, rd1: '0, rd2: '0, pc: pcD, pcPlus4: pcD + 32'd4,
                       rs1: rs1, rs2: rs2, rd: instrD[11:7], extImm: imm};

endmodule

//--- source/executeUnit.sv
`timescale 1ns/1ns

module executeUnit import cpuPkg::*; (
    input  idEx_t           idExE,
    input  fwdSel_t         fwdA,
    input  fwdSel_t         fwdB,
    input  logic [XLEN-1:0] mwResult,
    output exMw_t           exMwE,
    output logic            redirect,
    output logic [XLEN-1:0] redirectPc
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcBReg;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] aluResult;
    logic            equal;

    assign srcA    = (fwdA == FWD_MW) ? mwResult : idExE.rd1;
    assign srcBReg = (fwdB == FWD_MW) ? mwResult : idExE.rd2;
    assign srcB    = idExE.ctrl.aluSrc ? idExE.extImm : srcBReg;

    always_comb begin
        case (idExE.ctrl.aluOp)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = XLEN'($signed(srcA) < $signed(srcB));
            default: aluResult = '0;
        endcase
    end

    assign equal    = (srcA == srcBReg);
    assign redirect = idExE.ctrl.jump | (idExE.ctrl.branch & equal);

    // JALR clears bit 0 of its target.
    assign redirectPc = idExE.ctrl.jalr ? ((srcA + idExE.extImm) & ~32'd1)
                                        : (idExE.pc + idExE.extImm);

    assign exMwE = '{regWrite:  idExE.ctrl.regWrite,
                     resultSrc: idExE.ctrl.resultSrc,
                     memWrite:  idExE.ctrl.memWrite,
                     aluResult: aluResult,
                     writeData: srcBReg,
                     pcPlus4:   idExE.pcPlus4,
                     rd:        idExE.rd};

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ns

module fetchStage import cpuPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            stallF,
    input  logic            stallD,
    input  logic            flushD,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirectPc,
    input  logic [31:0]     imemData,
    output logic [XLEN-1:0] imemAddr,
    output logic [XLEN-1:0] pcD,
    output logic [31:0]     instrD
);

    logic [XLEN-1:0] pcF;

    assign imemAddr = pcF;

    // A redirect from execute wins over a load-use stall.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcF <= RESET_PC;
        end else if (redirect) begin
            pcF <= redirectPc;
        end else if (!stallF) begin
            pcF <= pcF + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD <= NOP_INSTR;
            pcD    <= RESET_PC;
        end else if (flushD) begin
            instrD <= NOP_INSTR;
            pcD    <= pcF;
        end else if (!stallD) begin
            instrD <= imemData;
            pcD    <= pcF;
        end
    end

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit import cpuPkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1D,
    input  logic [REG_ADDR_W-1:0] rs2D,
    input  idEx_t                 idExE,
    input  exMw_t                 mwDst,
    input  logic                  redirect,
    output fwdSel_t               fwdA,
    output fwdSel_t               fwdB,
    output logic                  stallF,
    output logic                  stallD,
    output logic                  flushD,
    output logic                  flushE
);

    logic mwWrites;
    logic loadUse;

    assign mwWrites = mwDst.regWrite && (mwDst.rd != '0);
    assign fwdA     = (mwWrites && mwDst.rd == idExE.rs1) ? FWD_MW : FWD_NONE;
    assign fwdB     = (mwWrites && mwDst.rd == idExE.rs2) ? FWD_MW : FWD_NONE;

    // A load in execute has no data yet for the instruction in decode.
    assign loadUse = idExE.ctrl.regWrite && (idExE.ctrl.resultSrc == RES_MEM) &&
                     (idExE.rd != '0) && (idExE.rd == rs1D || idExE.rd == rs2D);

    assign stallF = loadUse & ~redirect;
    assign stallD = loadUse & ~redirect;
    assign flushD = redirect;
    assign flushE = redirect | loadUse;

endmodule

//--- source/memWriteback.sv
`timescale 1ns/1ns

module memWriteback import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  exMw_t                 exMwE,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData,
    output exMw_t                 mwDst
);

    exMw_t                  mwReg;
    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] dmemIdx;
    logic [XLEN-1:0]        readData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mwReg <= '0;
        end else begin
            mwReg <= exMwE;
        end
    end

    // Data memory is word addressed. The two low address bits are ignored.
    assign dmemIdx  = mwReg.aluResult[DMEM_ADDR_W+1:2];
    assign readData = dmem[dmemIdx];

    always_ff @(posedge clk) begin
        if (mwReg.memWrite) begin
            dmem[dmemIdx] <= mwReg.writeData;
        end
    end

    always_comb begin
        case (mwReg.resultSrc)
            RES_MEM:  wbData = readData;
            RES_LINK: wbData = mwReg.pcPlus4;
            default:  wbData = mwReg.aluResult;
        endcase
    end

    assign wbValid = mwReg.regWrite && (mwReg.rd != '0);
    assign wbRd    = mwReg.rd;
    assign mwDst   = mwReg;

endmodule

//--- source/pipelineCpu.sv
`timescale 1ns/1ns

module pipelineCpu import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [31:0]           imemData,
    output logic [XLEN-1:0]       imemAddr,
    output logic                  wbValid,
    output logic [REG_ADDR_W-1:0] wbRd,
    output logic [XLEN-1:0]       wbData
);

    logic                  stallF;
    logic                  stallD;
    logic                  flushD;
    logic                  flushE;
    logic                  redirect;
    logic [XLEN-1:0]       redirectPc;
    logic [XLEN-1:0]       pcD;
    logic [31:0]           instrD;
    logic [REG_ADDR_W-1:0] rs1D;
    logic [REG_ADDR_W-1:0] rs2D;
    logic [XLEN-1:0]       rd1D;
    logic [XLEN-1:0]       rd2D;
    idEx_t                 decodedD;
    idEx_t                 idExD;
    idEx_t                 idExE;
    fwdSel_t               fwdA;
    fwdSel_t               fwdB;
    exMw_t                 exMwE;
    exMw_t                 mwDst;

    assign idExD = '{ctrl: decodedD.ctrl, rd1: rd1D, rd2: rd2D, pc: decodedD.pc,
                     pcPlus4: decodedD.pcPlus4, rs1: decodedD.rs1, rs2: decodedD.rs2,
                     rd: decodedD.rd, extImm: decodedD.extImm};

    fetchStage u_fetchStage (
        .clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .redirect(redirect), .redirectPc(redirectPc), .imemData(imemData),
        .imemAddr(imemAddr), .pcD(pcD), .instrD(instrD)
    );

    decodeUnit u_decodeUnit (
        .instrD(instrD), .pcD(pcD), .decoded(decodedD), .rs1(rs1D), .rs2(rs2D)
    );

    registerFile u_registerFile (
        .clk(clk), .arstN(arstN), .rs1(rs1D), .rs2(rs2D), .wbRd(wbRd),
        .wbValid(wbValid), .wbData(wbData), .rd1(rd1D), .rd2(rd2D)
    );

    decodeExecuteReg u_decodeExecuteReg (
        .clk(clk), .arstN(arstN), .flushE(flushE), .idExD(idExD), .idExE(idExE)
    );

    executeUnit u_executeUnit (
        .idExE(idExE), .fwdA(fwdA), .fwdB(fwdB), .mwResult(wbData), .exMwE(exMwE),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    memWriteback u_memWriteback (
        .clk(clk), .arstN(arstN), .exMwE(exMwE), .wbValid(wbValid), .wbRd(wbRd),
        .wbData(wbData), .mwDst(mwDst)
    );

    hazardUnit u_hazardUnit (
        .rs1D(rs1D), .rs2D(rs2D), .idExE(idExE), .mwDst(mwDst), .redirect(redirect),
        .fwdA(fwdA), .fwdB(fwdB), .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .flushE(flushE)
    );

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ns

module registerFile import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] wbRd,
    input  logic                  wbValid,
    input  logic [XLEN-1:0]       wbData,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2
);

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbRd] <= wbData;
        end
    end

    // A write in this cycle is visible to decode in the same cycle.
    always_comb begin
        if (rs1 == '0)                   rd1 = '0;
        else if (wbValid && wbRd == rs1) rd1 = wbData;
        else                             rd1 = regs[rs1];

        if (rs2 == '0)                   rd2 = '0;
        else if (wbValid && wbRd == rs2) rd2 = wbData;
        else                             rd2 = regs[rs2];
    end

endmodule

//--- src.f
source/cpuPkg.sv
source/fetchStage.sv
source/decodeUnit.sv
source/registerFile.sv
source/decodeExecuteReg.sv
source/executeUnit.sv
source/memWriteback.sv
source/hazardUnit.sv
source/pipelineCpu.sv
verif/pipelineCpuTb.sv

//--- verif/pipelineCpuTb.sv
`timescale 1ns/1ns

module pipelineCpuTb;

    localparam int CLK_PERIOD      = 10;
    localparam int DRIVE_DELAY     = 1;
    localparam int PREFIX_LEN      = 22;
    localparam int RANDOM_LEN      = 40;
    localparam int PROG_LEN        = PREFIX_LEN + RANDOM_LEN + 1;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 3 + 50;
    localparam int unsigned LCG_SEED = 86827;
    localparam logic [31:0] NOP       = 32'h0000_0013;
    localparam logic [31:0] SELF_LOOP = 32'h0000_006f;
    localparam logic [31:0] LOOP_PC   = (PROG_LEN - 1) * 4;

    logic        clk;
    logic        arstN;
    logic [31:0] imemData;
    logic [31:0] imemAddr;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] prog [PROG_LEN];
    int          progLen;
    int unsigned lcgState;
    logic [4:0]  expRd [$];
    logic [31:0] expVal [$];
    int          expCount;
    int          checkIdx;

    pipelineCpu u_pipelineCpu (
        .clk(clk), .arstN(arstN), .imemData(imemData), .imemAddr(imemAddr),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 8;
    endfunction

    function automatic logic [31:0] fetchWord(logic [31:0] addr);
        if (addr[31:2] < PROG_LEN) begin
            return prog[addr[31:2]];
        end else begin
            return NOP;
        end
    endfunction

    task automatic emit(logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        int unsigned r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prevRd;
        progLen = 0;
        emit(encI(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encI(12'd7, 5'd1, 3'b000, 5'd2, 7'b0010011));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        // The x0 write must vanish, and x5 must read x0 as zero.
        emit(encI(12'd9, 5'd1, 3'b000, 5'd0, 7'b0010011));
        emit(encR(7'h00, 5'd2, 5'd0, 3'b000, 5'd5));
        emit(encS(12'd8, 5'd3, 5'd0));
        emit(encI(12'd8, 5'd0, 3'b010, 5'd6, 7'b0000011));
        emit(encR(7'h00, 5'd1, 5'd6, 3'b000, 5'd7));
        // Taken branch over two writes, then a branch that falls through.
        emit(encB(13'd12, 5'd4, 5'd2));
        emit(encI(12'd99, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encI(12'd99, 5'd0, 3'b000, 5'd2, 7'b0010011));
        emit(encB(13'd12, 5'd2, 5'd1));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd1));
        emit(encR(7'h00, 5'd4, 5'd3, 3'b110, 5'd2));
        emit(encJ(21'd12, 5'd5));
        emit(encI(12'd1, 5'd0, 3'b000, 5'd6, 7'b0010011));
        emit(encI(12'd1, 5'd0, 3'b000, 5'd7, 7'b0010011));
        emit(encI(12'd84, 5'd0, 3'b000, 5'd3, 7'b0010011));
        emit(encI(12'd0, 5'd3, 3'b000, 5'd4, 7'b1100111));
        emit(encI(12'd1, 5'd0, 3'b000, 5'd7, 7'b0010011));
        emit(encR(7'h00, 5'd4, 5'd1, 3'b010, 5'd7));
        prevRd = 5'd7;
        for (int i = 0; i < RANDOM_LEN; i++) begin
            r   = nextRandom();
            rd  = 5'(r[5:3]);
            rs1 = r[20] ? prevRd : 5'(r[8:6]);
            rs2 = 5'(r[11:9]);
            case (r % 7)
                0:       emit(encR(7'h00, rs2, rs1, 3'b000, rd));
                1:       emit(encR(7'h20, rs2, rs1, 3'b000, rd));
                2:       emit(encR(7'h00, rs2, rs1, 3'b111, rd));
                3:       emit(encR(7'h00, rs2, rs1, 3'b110, rd));
                4:       emit(encR(7'h00, rs2, rs1, 3'b100, rd));
                5:       emit(encR(7'h00, rs2, rs1, 3'b010, rd));
                default: emit(encI(r[23:12], rs1, 3'b000, rd, 7'b0010011));
            endcase
            prevRd = rd;
        end
        emit(SELF_LOOP);
    endtask

    // Sequential execution of the program, recording every write to a nonzero register.
    task automatic runReferenceModel();
        logic [31:0] regs [32];
        logic [31:0] dmem [64];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic        wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            instr = fetchWord(pc);
            if (instr == SELF_LOOP) break;
            a      = regs[instr[19:15]];
            b      = regs[instr[24:20]];
            immI   = {{20{instr[31]}}, instr[31:20]};
            immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            nextPc = pc + 4;
            res    = '0;
            wr     = 1'b1;
            case (instr[6:0])
                7'b0110011: begin
                    case (instr[14:12])
                        3'b000:  res = instr[30] ? a - b : a + b;
                        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + immI;
                7'b0000011: begin
                    addr = a + immI;
                    res  = dmem[addr[7:2]];
                end
                7'b0100011: begin
                    addr = a + immS;
                    dmem[addr[7:2]] = b;
                    wr = 1'b0;
                end
                7'b1100011: begin
                    if (a == b) nextPc = pc + immB;
                    wr = 1'b0;
                end
                7'b1101111: begin
                    res    = pc + 4;
                    nextPc = pc + immJ;
                end
                default: begin
                    res    = pc + 4;
                    nextPc = (a + immI) & ~32'd1;
                end
            endcase
            if (wr && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] = res;
                expRd.push_back(instr[11:7]);
                expVal.push_back(res);
            end
            pc = nextPc;
        end
        expCount = expRd.size();
    endtask

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
        $display("Fail %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
        abortRun();
    endtask

    task automatic reportProblem(string what);
        $display("Error: %s", what);
        abortRun();
    endtask

    // Instruction memory answers the new PC shortly after each edge.
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        imemData = fetchWord(imemAddr);
    end

    // Retire outputs are sampled on the falling edge, away from register updates.
    always @(negedge clk) begin
        if (arstN) begin
            assert (!$isunknown(wbValid))
                else reportProblem("wbValid is unknown after reset");
            if (wbValid) begin
                assert (checkIdx < expCount)
                    else reportProblem("the DUT retired more register writes than expected");
                assert (wbRd == expRd[checkIdx])
                    else reportMismatch($sformatf("retire %0d rd", checkIdx),
                                        32'(expRd[checkIdx]), 32'(wbRd));
                assert (wbData == expVal[checkIdx])
                    else reportMismatch($sformatf("retire %0d data", checkIdx),
                                        expVal[checkIdx], wbData);
                checkIdx++;
            end
        end
    end

    initial begin
        #((WATCHDOG_CYCLES + 4) * CLK_PERIOD);
        reportProblem($sformatf("timeout, only %0d of %0d writes retired", checkIdx, expCount));
    end

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        imemData = NOP;
        checkIdx = 0;
        lcgState = LCG_SEED;
        buildProgram();
        runReferenceModel();
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        arstN = 1'b1;
        wait (checkIdx == expCount);
        // A few more cycles show the loop running with no stray writes.
        repeat (10) @(posedge clk);
        #(DRIVE_DELAY);
        assert (imemAddr >= LOOP_PC && imemAddr <= LOOP_PC + 8)
            else reportProblem("the core is not running the final self-loop");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
